//--- tb.f
+incdir+verilog
verilog/ifu_pkg.sv
verilog/icache_line.sv
verilog/icache_refill.sv
verilog/fetch_ctrl.sv
verilog/ifu_top.sv
tb/ifu_mem_model.sv
tb/ifu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the fetch unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ifu_tb -f tb.f -o ifu_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/ifu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^TEST RESULT: PASS$"; then
  exit 0
fi
exit 1

//--- tb/ifu_tb.sv
`timescale 1ns/1ps
`include "ifu_params.svh"

module ifu_tb import ifu_pkg::*; ();

  localparam int    CLK_PERIOD  = 40;
  localparam int    NUM_TESTS   = 6;
  localparam int    TEST_CYCLES = 400;
  localparam int    WAIT_LIMIT  = 60;
  localparam addr_t BASE        = `IFU_PC_INIT;
  localparam inst_t JAL_W       = {25'd512, `IFU_OP_JAL};
  localparam inst_t BEQ_W       = {25'd0, `IFU_OP_BRANCH};
  localparam inst_t LW_W        = {25'd65, `IFU_OP_LOAD};   // lw x1, 0(x0).

  logic       clk;
  logic       rst;
  logic       next_ready;
  addr_t      bus_araddr;
  logic       bus_arvalid;
  inst_t      bus_rdata;
  logic       bus_rvalid;
  fetch_pkt_t fetch_pkt;
  logic       valid;
  resolve_t   resolve;
  logic       spec;
  logic       good_spec;
  logic       bad_spec;
  inst_t      prog [64];
  int         errors;
  int         checks;

  ifu_top ifu_top_inst (
    .clk           (clk),
    .rst           (rst),
    .bus_araddr_o  (bus_araddr),
    .bus_arvalid_o (bus_arvalid),
    .bus_rdata_i   (bus_rdata),
    .bus_rvalid_i  (bus_rvalid),
    .fetch_pkt_o   (fetch_pkt),
    .valid_o       (valid),
    .next_ready_i  (next_ready),
    .resolve_i     (resolve),
    .spec_o        (spec),
    .good_spec_o   (good_spec),
    .bad_spec_o    (bad_spec)
  );

  ifu_mem_model mem_model_inst (
    .clk       (clk),
    .rst       (rst),
    .araddr_i  (bus_araddr),
    .arvalid_i (bus_arvalid),
    .rdata_o   (bus_rdata),
    .rvalid_o  (bus_rvalid)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
    $display("watchdog expired before all tests finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // ============================================================
  // program, reset and check helpers
  // ============================================================
  function automatic inst_t fill_word(input addr_t addr);
    return {addr[31:7] ^ {addr[6:0], addr[31:14]}, 7'b001_0011};  // op-imm only.
  endfunction

  task automatic set_word(input addr_t addr, input inst_t inst);
    prog[addr[7:2]]               = inst;
    mem_model_inst.mem[addr[7:2]] = inst;
  endtask

  task automatic fill_prog();
    for (int i = 0; i < 64; i++) begin
      set_word(BASE + 32'(4 * i), fill_word(BASE + 32'(4 * i)));
    end
  endtask

  task automatic apply_reset();
    rst        = 1'b1;
    next_ready = 1'b0;
    resolve    = '0;
    repeat (5) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    checks++;
    assert (actual === expected)
      else begin
        errors++;
        $display("ERROR %s: expected %b, actual %b", name, expected, actual);
      end
  endtask

  task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
    checks++;
    assert (actual === expected)
      else begin
        errors++;
        $display("ERROR %s: expected %h, actual %h", name, expected, actual);
      end
  endtask

  task automatic check_pkt(input string name, input fetch_pkt_t expected,
                           input fetch_pkt_t actual);
    checks++;
    assert (actual === expected)
      else begin
        errors++;
        $display("ERROR %s: expected %h, actual %h", name, expected, actual);
      end
  endtask

  // accepts one packet and notes whether a refill ran while waiting.
  task automatic take(input string name, input addr_t pc, output logic missed);
    fetch_pkt_t expected;
    int         n;
    expected.pc   = pc;
    expected.inst = prog[pc[7:2]];
    n             = 0;
    missed        = 1'b0;
    next_ready    = 1'b1;
    while (!valid && n < WAIT_LIMIT) begin
      missed = missed | bus_arvalid;
      if (bus_arvalid) begin
        check_addr({name, " bus address"}, {pc[31:3], 3'b000},
                   {bus_araddr[31:3], 1'b0, bus_araddr[1:0]});  // word 0 or word 1 of the line.
      end
      @(negedge clk);
      n++;
    end
    assert (valid)
      else begin
        errors++;
        $display("ERROR %s: no packet offered for pc %h", name, pc);
      end
    check_pkt(name, expected, fetch_pkt);
    @(negedge clk);
    next_ready = 1'b0;
  endtask

  task automatic expect_idle(input string name, input int cycles);
    next_ready = 1'b1;
    repeat (cycles) begin
      check_bit(name, 1'b0, valid);
      @(negedge clk);
    end
    next_ready = 1'b0;
  endtask

  task automatic strobe(input logic redirect, input logic retire, input addr_t npc,
                        input addr_t retire_pc);
    resolve = {redirect, retire, npc, retire_pc};
    @(negedge clk);
    resolve = '0;
  endtask

  // ============================================================
  // directed tests
  // ============================================================
  task automatic reset_and_first_fetch();
    logic missed;
    fill_prog();
    apply_reset();
    check_bit("reset valid", 1'b0, valid);
    check_bit("reset arvalid", 1'b0, bus_arvalid);
    check_bit("reset spec", 1'b0, spec | good_spec | bad_spec);
    take("first fetch", BASE, missed);
    check_bit("first fetch refill", 1'b1, missed);
  endtask

  task automatic sequential_fetch();
    logic missed;
    fill_prog();
    apply_reset();
    for (int i = 0; i < 6; i++) begin
      take("sequential", BASE + 32'(4 * i), missed);
      check_bit("sequential refill", (i % 2) == 0, missed);  // word 1 hits the line.
    end
  endtask

  task automatic back_pressure();
    fetch_pkt_t held;
    logic       missed;
    fill_prog();
    apply_reset();
    take("back-pressure", BASE, missed);
    held.pc   = BASE + 32'd4;
    held.inst = prog[1];
    repeat (6) begin
      check_bit("back-pressure valid", 1'b1, valid);
      check_pkt("back-pressure hold", held, fetch_pkt);
      @(negedge clk);
    end
    for (int i = 1; i < 4; i++) begin
      take("back-pressure", BASE + 32'(4 * i), missed);
    end
  endtask

  task automatic hazard_stalls();
    logic missed;
    fill_prog();
    set_word(BASE + 32'd4, LW_W);
    set_word(BASE + 32'd12, JAL_W);
    apply_reset();
    take("hazard", BASE, missed);
    take("hazard load", BASE + 32'd4, missed);
    expect_idle("hazard load stall", 5);
    strobe(1'b0, 1'b1, '0, BASE + 32'd4);
    take("hazard after retire", BASE + 32'd8, missed);
    take("hazard jal", BASE + 32'd12, missed);
    expect_idle("hazard jal stall", 5);
    strobe(1'b1, 1'b0, BASE + 32'd48, '0);
    take("hazard after redirect", BASE + 32'd48, missed);
  endtask

  task automatic speculation();
    logic missed;
    fill_prog();
    set_word(BASE, JAL_W);
    set_word(BASE + 32'd20, BEQ_W);
    set_word(BASE + 32'd32, LW_W);
    set_word(BASE + 32'd36, BEQ_W);
    apply_reset();
    take("spec train", BASE, missed);
    strobe(1'b1, 1'b0, BASE + 32'd16, '0);                // predictor learns 0x10.
    take("spec train", BASE + 32'd16, missed);
    take("spec branch", BASE + 32'd20, missed);
    check_bit("spec open", 1'b1, spec);
    take("spec target", BASE + 32'd16, missed);
    strobe(1'b1, 1'b0, BASE + 32'd16, '0);
    check_bit("good pulse", 1'b1, good_spec);
    check_bit("good closes", 1'b0, spec);
    take("spec branch", BASE + 32'd20, missed);
    check_bit("good pulse end", 1'b0, good_spec);
    check_bit("spec reopen", 1'b1, spec);
    take("spec target", BASE + 32'd16, missed);
    strobe(1'b1, 1'b0, BASE + 32'd32, '0);                // wrong guess.
    check_bit("bad flag", 1'b1, bad_spec);
    check_bit("bad closes", 1'b0, spec);
    take("bad redirect", BASE + 32'd32, missed);
    strobe(1'b0, 1'b1, '0, BASE + 32'd32);
    take("spec branch", BASE + 32'd36, missed);
    check_bit("spec on load", 1'b1, spec);
    expect_idle("load under guess", 5);
    strobe(1'b1, 1'b0, BASE + 32'd32, '0);
    check_bit("good on load", 1'b1, good_spec);
    take("load after guess", BASE + 32'd32, missed);
  endtask

  task automatic fence_i_flush();
    logic missed;
    fill_prog();
    set_word(BASE + 32'd4, `IFU_INST_FENCE_I);
    set_word(BASE + 32'd12, JAL_W);
    apply_reset();
    for (int i = 0; i < 4; i++) begin
      take("fence.i", BASE + 32'(4 * i), missed);
    end
    strobe(1'b1, 1'b0, BASE, '0);
    take("fence.i refetch", BASE, missed);
    check_bit("fence.i refill", 1'b1, missed);
  endtask

  initial begin
    rst        = 1'b1;
    next_ready = 1'b0;
    resolve    = '0;
    errors     = 0;
    checks     = 0;
    reset_and_first_fetch();
    sequential_fetch();
    back_pressure();
    hazard_stalls();
    speculation();
    fence_i_flush();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- tb/ifu_mem_model.sv
`timescale 1ns/1ps
`include "ifu_params.svh"

module ifu_mem_model import ifu_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  addr_t araddr_i,
  input  logic  arvalid_i,
  output inst_t rdata_o,
  output logic  rvalid_o
);

  inst_t       mem [64];                                  // word address bits 7:2.
  logic [31:0] seed;
  logic        busy;
  int          wait_cnt;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  initial begin
    seed     = 32'hecca_efe4;
    busy     = 1'b0;
    wait_cnt = 0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
  end

  // answers on the falling edge, 1 to 4 cycles after the request.
  always @(negedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      rvalid_o <= 1'b0;
    end else if (rvalid_o) begin
      busy     <= 1'b0;                                   // word taken at the last edge.
      rvalid_o <= 1'b0;
    end else if (arvalid_i && !busy) begin
      seed     <= lcg_next(seed);
      wait_cnt <= int'(seed[30:29]);
      busy     <= 1'b1;
    end else if (busy && wait_cnt != 0) begin
      wait_cnt <= wait_cnt - 1;
    end else if (busy) begin
      rdata_o  <= mem[araddr_i[7:2]];
      rvalid_o <= 1'b1;
    end
  end

endmodule

//--- verilog/ifu_top.sv
`timescale 1ns/1ps
`include "ifu_params.svh"

module ifu_top import ifu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  output addr_t      bus_araddr_o,
  output logic       bus_arvalid_o,
  input  inst_t      bus_rdata_i,
  input  logic       bus_rvalid_i,
  output fetch_pkt_t fetch_pkt_o,
  output logic       valid_o,
  input  logic       next_ready_i,
  input  resolve_t   resolve_i,
  output logic       spec_o,
  output logic       good_spec_o,
  output logic       bad_spec_o
);

  logic [`IFU_SETS-1:0]                  line_hit;
  inst_t [`IFU_SETS-1:0][`IFU_WORDS-1:0] line_words;
  line_wr_t                              line_wr;
  addr_t                                 fetch_pc;
  tag_t                                  fetch_tag;
  logic                                  miss;
  logic                                  refill_busy;
  logic                                  invalidate;

  fetch_ctrl fetch_ctrl_inst (
    .clk           (clk),
    .rst           (rst),
    .line_hit_i    (line_hit),
    .line_words_i  (line_words),
    .pc_o          (fetch_pc),
    .tag_o         (fetch_tag),
    .miss_o        (miss),
    .refill_busy_i (refill_busy),
    .invalidate_o  (invalidate),
    .fetch_pkt_o   (fetch_pkt_o),
    .valid_o       (valid_o),
    .next_ready_i  (next_ready_i),
    .resolve_i     (resolve_i),
    .spec_o        (spec_o),
    .good_spec_o   (good_spec_o),
    .bad_spec_o    (bad_spec_o)
  );

  icache_refill icache_refill_inst (
    .clk           (clk),
    .rst           (rst),
    .miss_i        (miss),
    .pc_i          (fetch_pc),
    .bus_araddr_o  (bus_araddr_o),
    .bus_arvalid_o (bus_arvalid_o),
    .bus_rdata_i   (bus_rdata_i),
    .bus_rvalid_i  (bus_rvalid_i),
    .line_wr_o     (line_wr),
    .busy_o        (refill_busy)
  );

  // one line per set, each picks its own writes by index.
  for (genvar g = 0; g < `IFU_SETS; g++) begin : g_line
    icache_line #(
      .LINE_IDX (g)
    ) icache_line_inst (
      .clk          (clk),
      .rst          (rst),
      .wr_i         (line_wr),
      .invalidate_i (invalidate),
      .tag_i        (fetch_tag),
      .hit_o        (line_hit[g]),
      .word0_o      (line_words[g][0]),
      .word1_o      (line_words[g][1])
    );
  end

endmodule

//--- verilog/fetch_ctrl.sv
`timescale 1ns/1ps
`include "ifu_params.svh"

module fetch_ctrl import ifu_pkg::*; (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [`IFU_SETS-1:0]                  line_hit_i,
  input  inst_t [`IFU_SETS-1:0][`IFU_WORDS-1:0] line_words_i,
  output addr_t                                 pc_o,
  output tag_t                                  tag_o,
  output logic                                  miss_o,
  input  logic                                  refill_busy_i,
  output logic                                  invalidate_o,
  output fetch_pkt_t                            fetch_pkt_o,
  output logic                                  valid_o,
  input  logic                                  next_ready_i,
  input  resolve_t                              resolve_i,
  output logic                                  spec_o,
  output logic                                  good_spec_o,
  output logic                                  bad_spec_o
);

  fetch_state_e             state_q;
  addr_t                    pc_q;
  addr_t                    btb_q;                          // last redirect target.
  logic                     btb_valid_q;
  logic                     spec_q;
  addr_t                    spec_target_q;
  addr_t                    spec_fall_q;                    // pc+4 of the guessed branch.
  logic                     good_q;
  logic                     bad_q;
  logic                     bad_redirect_q;
  addr_t                    bad_npc_q;

  index_t                   cur_index;
  logic [`IFU_WORDS_LOG-1:0] cur_word;
  logic                     cur_hit;
  inst_t                    cur_inst;
  logic [6:0]               opcode;
  logic                     is_branch;
  logic                     is_load;
  logic                     is_store;
  logic                     is_fence_i;
  addr_t                    pc_plus4;
  addr_t                    retire_next;
  logic                     good_now;
  logic                     bad_now;
  logic                     fire;

  // ============================================================
  // lookup and classing
  // ============================================================
  assign cur_index = pc_q[`IFU_TAG_LSB-1:`IFU_OFFSET_W];
  assign cur_word  = pc_q[`IFU_OFFSET_W-1:2];
  assign cur_hit   = line_hit_i[cur_index];
  assign cur_inst  = line_words_i[cur_index][cur_word];

  assign opcode     = cur_inst[6:0];
  assign is_branch  = (opcode == `IFU_OP_JAL) || (opcode == `IFU_OP_JALR) ||
                      (opcode == `IFU_OP_BRANCH) || (opcode == `IFU_OP_SYSTEM);
  assign is_load    = (opcode == `IFU_OP_LOAD);
  assign is_store   = (opcode == `IFU_OP_STORE);
  assign is_fence_i = (cur_inst == `IFU_INST_FENCE_I);

  assign pc_plus4    = pc_q + 32'd4;
  assign retire_next = resolve_i.retire_pc + 32'd4;

  // a redirect wins over a retire in the same cycle.
  assign good_now = spec_q && (resolve_i.redirect ? (resolve_i.npc == spec_target_q) :
                               (resolve_i.retire && (retire_next == spec_target_q)));
  assign bad_now  = spec_q && (resolve_i.redirect ? (resolve_i.npc != spec_target_q) :
                               (resolve_i.retire && (retire_next != spec_target_q)));

  assign valid_o = (state_q == RUN) && cur_hit && !bad_now &&
                   !(spec_q && (is_load || is_store));      // no memory ops under a guess.
  assign fire    = valid_o && next_ready_i;

  assign fetch_pkt_o  = '{pc: pc_q, inst: cur_inst};
  assign pc_o         = pc_q;
  assign tag_o        = pc_q[31:`IFU_TAG_LSB];
  assign miss_o       = (state_q == RUN) && !cur_hit && !bad_now;
  assign invalidate_o = fire && is_fence_i;

  assign spec_o      = spec_q;
  assign good_spec_o = good_q;
  assign bad_spec_o  = bad_q || bad_now;

  // ============================================================
  // fetch state, predictor and guess tracking
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= RUN;
      pc_q        <= `IFU_PC_INIT;
      btb_valid_q <= 1'b0;
      spec_q      <= 1'b0;
      good_q      <= 1'b0;
      bad_q       <= 1'b0;
    end else begin
      good_q <= good_now;
      if (resolve_i.redirect) begin
        btb_q       <= resolve_i.npc;
        btb_valid_q <= 1'b1;
      end
      case (state_q)
        RUN: begin
          if (fire) begin
            if (is_load) begin
              state_q <= HAZARD;
            end else if (is_branch && btb_valid_q && !spec_q) begin
              pc_q          <= btb_q;                       // follow the guess.
              spec_q        <= 1'b1;
              spec_target_q <= btb_q;
              spec_fall_q   <= pc_plus4;
            end else if (is_branch) begin
              state_q <= HAZARD;
            end else begin
              pc_q <= pc_plus4;
            end
          end
        end
        HAZARD: begin
          // strobes belong to the open guess first.
          if (!spec_q && resolve_i.redirect) begin
            pc_q    <= resolve_i.npc;
            state_q <= RUN;
          end else if (!spec_q && resolve_i.retire) begin
            pc_q    <= pc_plus4;
            state_q <= RUN;
          end
        end
        FLUSH: begin
          if (!refill_busy_i) begin
            pc_q    <= bad_redirect_q ? bad_npc_q : spec_fall_q;
            bad_q   <= 1'b0;
            state_q <= RUN;
          end
        end
        default: begin
          state_q <= RUN;
        end
      endcase
      if (good_now) begin
        spec_q <= 1'b0;
      end
      if (bad_now) begin
        spec_q         <= 1'b0;
        bad_q          <= 1'b1;
        bad_redirect_q <= resolve_i.redirect;
        bad_npc_q      <= resolve_i.npc;
        state_q        <= FLUSH;
      end
    end
  end

  // the missing line is never offered before its refill ends.
  a_no_valid_in_refill: assert property (@(posedge clk) disable iff (rst)
    valid_o |-> !refill_busy_i)
    else $error("fetch_ctrl: packet offered while a refill is running");

endmodule

//--- verilog/icache_refill.sv
`timescale 1ns/1ps
`include "ifu_params.svh"

module icache_refill import ifu_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     miss_i,
  input  addr_t    pc_i,
  output addr_t    bus_araddr_o,
  output logic     bus_arvalid_o,
  input  inst_t    bus_rdata_i,
  input  logic     bus_rvalid_i,
  output line_wr_t line_wr_o,
  output logic     busy_o
);

  refill_state_e state_q;
  addr_t         base_q;                                    // line base of the miss.
  line_wr_t      wr_q;
  logic          word_sel;
  logic          word_done;

  assign word_sel  = (state_q == REQ1);
  assign word_done = bus_arvalid_o && bus_rvalid_i;

  // ============================================================
  // miss state machine
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          if (miss_i) begin
            state_q <= REQ0;
          end
        end
        REQ0: begin
          if (bus_rvalid_i) begin
            state_q <= REQ1;
          end
        end
        REQ1: begin
          if (bus_rvalid_i) begin
            state_q <= DONE;
          end
        end
        DONE: begin
          state_q <= IDLE;                                  // last word lands this cycle.
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == IDLE && miss_i) begin
      base_q <= {pc_i[31:`IFU_OFFSET_W], {`IFU_OFFSET_W{1'b0}}};
    end
  end

  assign bus_arvalid_o = (state_q == REQ0) || (state_q == REQ1);
  assign bus_araddr_o  = {base_q[31:`IFU_OFFSET_W], word_sel, 2'b00};
  assign busy_o        = (state_q != IDLE);

  // ============================================================
  // line write, one cycle behind the bus word
  // ============================================================
  always_ff @(posedge clk) begin
    wr_q.index <= base_q[`IFU_TAG_LSB-1:`IFU_OFFSET_W];
    wr_q.word  <= word_sel;
    wr_q.tag   <= base_q[31:`IFU_TAG_LSB];
    wr_q.data  <= bus_rdata_i;
    if (rst) begin
      wr_q.en <= 1'b0;
    end else begin
      wr_q.en <= word_done;
    end
  end

  assign line_wr_o = wr_q;

  // a bus word only answers an open request.
  a_rvalid_in_req: assert property (@(posedge clk) disable iff (rst)
    bus_rvalid_i |-> bus_arvalid_o)
    else $error("icache_refill: read data without a request");

  a_addr_stable: assert property (@(posedge clk) disable iff (rst)
    (bus_arvalid_o && !bus_rvalid_i) |=> (bus_arvalid_o && $stable(bus_araddr_o)))
    else $error("icache_refill: request changed while waiting");

endmodule

//--- verilog/icache_line.sv
`timescale 1ns/1ps

module icache_line import ifu_pkg::*; #(
  parameter int LINE_IDX = 0
) (
  input  logic     clk,
  input  logic     rst,
  input  line_wr_t wr_i,
  input  logic     invalidate_i,
  input  tag_t     tag_i,
  output logic     hit_o,
  output inst_t    word0_o,
  output inst_t    word1_o
);

  logic  valid_q;
  tag_t  tag_q;
  inst_t word0_q;
  inst_t word1_q;
  logic  sel;

  assign sel = wr_i.en && (wr_i.index == index_t'(LINE_IDX));

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (invalidate_i) begin
      valid_q <= 1'b0;                                      // fence.i.
    end else if (sel) begin
      valid_q <= wr_i.word;                                 // word 0 opens, word 1 closes.
    end
  end

  always_ff @(posedge clk) begin
    if (sel && !wr_i.word) begin
      word0_q <= wr_i.data;
      tag_q   <= wr_i.tag;
    end
    if (sel && wr_i.word) begin
      word1_q <= wr_i.data;
    end
  end

  assign hit_o   = valid_q && (tag_q == tag_i);
  assign word0_o = word0_q;
  assign word1_o = word1_q;

  // the second word belongs to the line that the first word started.
  a_word1_tag: assert property (@(posedge clk) disable iff (rst)
    (sel && wr_i.word) |-> (wr_i.tag == tag_q))
    else $error("icache_line %0d: word 1 tag differs from word 0", LINE_IDX);

endmodule

//--- verilog/ifu_pkg.sv
`include "ifu_params.svh"

package ifu_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [`IFU_SETS_LOG-1:0] index_t;                // pc bits 4:3.
  typedef logic [31-`IFU_TAG_LSB:0] tag_t;                  // pc bits 31:5.

  typedef struct packed {
    addr_t pc;
    inst_t inst;
  } fetch_pkt_t;

  // one refill word going into the line array.
  typedef struct packed {
    logic   en;
    index_t index;
    logic   word;
    tag_t   tag;
    inst_t  data;
  } line_wr_t;

  typedef struct packed {
    logic  redirect;                                        // strobe, npc is taken.
    logic  retire;                                          // strobe, retire_pc done.
    addr_t npc;
    addr_t retire_pc;
  } resolve_t;

  typedef enum logic [1:0] {
    IDLE,
    REQ0,
    REQ1,
    DONE
  } refill_state_e;

  typedef enum logic [1:0] {
    RUN,
    HAZARD,
    FLUSH
  } fetch_state_e;

endpackage

//--- verilog/ifu_params.svh
`ifndef IFU_PARAMS_SVH
`define IFU_PARAMS_SVH

// ============================================================
// fetch start and cache geometry
// ============================================================
`define IFU_PC_INIT      32'h8000_0000
`define IFU_SETS_LOG     2
`define IFU_WORDS_LOG    1
`define IFU_SETS         (1 << `IFU_SETS_LOG)
`define IFU_WORDS        (1 << `IFU_WORDS_LOG)
`define IFU_OFFSET_W     (`IFU_WORDS_LOG + 2)                 // byte offset in a line.
`define IFU_TAG_LSB      (`IFU_SETS_LOG + `IFU_OFFSET_W)

// ============================================================
// rv32i opcodes seen by fetch
// ============================================================
`define IFU_OP_JAL       7'b110_1111
`define IFU_OP_JALR      7'b110_0111
`define IFU_OP_BRANCH    7'b110_0011
`define IFU_OP_SYSTEM    7'b111_0011
`define IFU_OP_LOAD      7'b000_0011
`define IFU_OP_STORE     7'b010_0011

`define IFU_INST_FENCE_I 32'h0000_100f                        // fence.i, all fields zero.

`endif
